// File: files.f
cache_pkg.sv
xfer_if.sv
event_sync.sv
dual_clock_ram.sv
cache_lookup.sv
mem_sequencer.sv
snowball_cache.sv
tb_clock_gen.sv
tb_snowball_cache.sv

// File: Makefile
# Verilator build and run for the cache testbench

VERILATOR ?= verilator
TOP       ?= tb_snowball_cache
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0 --timescale 1ns/1ps
PASS_MSG  ?= Test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_snowball_cache.sv
//--------------------------------------------------
// tb_snowball_cache
// table-driven testbench with a memory model behind
// the bus and a random bus grant
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_snowball_cache;

  localparam int n_rows      = 14;
  localparam int cycle_limit = 400 * n_rows;
  localparam logic [1:0] op_rd  = 2'd0;
  localparam logic [1:0] op_wr  = 2'd1;
  localparam logic [1:0] op_tlb = 2'd2;

  wire CPU_CLK;
  wire MCU_CLK;
  logic RST, cache_precycle_we, cache_precycle_enable, cache_inhibit, vmem_act, we_tlb;
  logic dma_mcu_access, mem_ack;
  logic [31:0] cache_precycle_addr, cache_datao, mem_datafrommem;
  wire [31:0] cache_datai, mem_addr, mem_dataintomem;
  wire cache_busy, mmu_fault, mem_we, mem_do_act;

  // stimulus table
  logic [1:0]  t_op [n_rows];
  logic        t_vmem [n_rows];
  logic        t_inh [n_rows];
  logic [31:0] t_addr [n_rows];
  logic [31:0] t_data [n_rows];
  logic        t_bus [n_rows];       // one bus cycle and busy raised
  logic [31:0] t_bus_addr [n_rows];
  logic [31:0] t_rdata [n_rows];
  logic        t_fault [n_rows];

  logic [31:0] mem_model [logic [31:0]];
  logic [31:0] bus_addr, bus_data;
  logic        bus_we;
  int bus_cnt = 0, act_cnt = 0, grant_err = 0;
  int err_cnt = 0, chk_cnt = 0, rows_done = 0, row_fill = 0, cycle_cnt = 0;

  tb_clock_gen #(.period_ns(100), .phase_ns(50)) u_cpu_clk (.clk(CPU_CLK));
  tb_clock_gen #(.period_ns(100), .phase_ns(80)) u_mcu_clk (.clk(MCU_CLK)); // 30 ns later

  snowball_cache DUT (
    .CPU_CLK, .MCU_CLK, .RST, .cache_precycle_addr, .cache_datao, .cache_datai,
    .cache_precycle_we, .cache_precycle_enable, .cache_inhibit, .vmem_act, .we_tlb,
    .cache_busy, .mmu_fault, .dma_mcu_access, .mem_addr, .mem_dataintomem, .mem_we,
    .mem_do_act, .mem_ack, .mem_datafrommem
  );

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // contents of a word never written
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    fill_word = {a[15:0], a[31:16]} ^ (a << 3) ^ 32'h5A3C_96E1;
  endfunction

  function automatic logic [31:0] mem_read(input logic [31:0] a);
    mem_read = mem_model.exists(a) ? mem_model[a] : fill_word(a);
  endfunction

  //--------------------------------------------------
  // memory model, MCU_CLK side
  //--------------------------------------------------
  initial
  begin : memory_side
    logic [15:0] lfsr;
    logic [31:0] rd_addr;
    logic        rd_pend;
    int          age;
    lfsr = 16'd35470;
    rd_addr = '0;
    rd_pend = 1'b0;
    age = 0;
    dma_mcu_access = 1'b0;
    mem_ack = 1'b0;
    mem_datafrommem = '0;
    forever
    begin
      @(posedge MCU_CLK);
      #5;
      dma_mcu_access = lfsr[0];        // one bit per cycle
      lfsr = lfsr_step(lfsr);
      #1;
      if (mem_do_act)
        act_cnt++;
      if (mem_do_act && !dma_mcu_access)
      begin
        grant_err++;
        $display("error at %0t: mem_do_act is high without dma_mcu_access", $time);
      end
      if (rd_pend)
      begin
        age++;
        if (age == 3)
          mem_datafrommem = mem_read(rd_addr);          // 2 cycles after registered ack
        else if (age == 4)
        begin
          mem_datafrommem = mem_read(rd_addr ^ 32'd1);  // companion word
          rd_pend = 1'b0;
        end
      end
      mem_ack = mem_do_act;            // ack lands with the strobe at the next edge
      if (mem_do_act)
      begin
        bus_cnt++;
        bus_addr = mem_addr;
        bus_data = mem_dataintomem;
        bus_we   = mem_we;
        if (mem_we)
          mem_model[mem_addr] = mem_dataintomem;
        else
        begin
          rd_pend = 1'b1;
          rd_addr = mem_addr;
          age = 0;
        end
      end
    end
  end

  //--------------------------------------------------
  // tasks for the CPU side
  //--------------------------------------------------
  task automatic next_cycle();
    @(posedge CPU_CLK);
    #5;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic add_row(input logic [1:0] op, input logic vmem, input logic inh,
                         input logic [31:0] addr, input logic [31:0] data,
                         input logic bus, input logic [31:0] bus_a,
                         input logic [31:0] rdata, input logic fault);
    t_op[row_fill]       = op;
    t_vmem[row_fill]     = vmem;
    t_inh[row_fill]      = inh;
    t_addr[row_fill]     = addr;
    t_data[row_fill]     = data;
    t_bus[row_fill]      = bus;
    t_bus_addr[row_fill] = bus_a;
    t_rdata[row_fill]    = rdata;
    t_fault[row_fill]    = fault;
    row_fill++;
  endtask

  task automatic load_table();
    // write-through, then a hit on it
    add_row(op_wr, 0, 0, 32'h0001_0420, 32'hCAFE_0001, 1, 32'h0001_0420, 32'h0, 0);
    add_row(op_rd, 0, 0, 32'h0001_0420, 32'h0, 0, 32'h0, 32'hCAFE_0001, 0);
    // miss, then companion and repeat hits
    add_row(op_rd, 0, 0, 32'h0002_0550, 32'h0, 1, 32'h0002_0550, fill_word(32'h0002_0550), 0);
    add_row(op_rd, 0, 0, 32'h0002_0551, 32'h0, 0, 32'h0, fill_word(32'h0002_0551), 0);
    add_row(op_rd, 0, 0, 32'h0002_0550, 32'h0, 0, 32'h0, fill_word(32'h0002_0550), 0);
    // TLB index 0x12 maps page 7A01 to 00C4
    add_row(op_tlb, 0, 0, 32'h0000_1200, 32'h00C4_7A01, 1, 32'h0000_1200, 32'h0, 0);
    add_row(op_rd, 1, 0, 32'h7A01_1234, 32'h0, 1, 32'h00C4_1234, fill_word(32'h00C4_1234), 0);
    add_row(op_rd, 1, 0, 32'h7A01_1235, 32'h0, 0, 32'h0, fill_word(32'h00C4_1235), 0);
    add_row(op_rd, 1, 0, 32'h7B01_1234, 32'h0, 0, 32'h0, 32'h0, 1);
    add_row(op_wr, 1, 0, 32'h7A01_1240, 32'h1234_5678, 1, 32'h00C4_1240, 32'h0, 0);
    add_row(op_rd, 1, 0, 32'h7A01_1240, 32'h0, 0, 32'h0, 32'h1234_5678, 0);
    add_row(op_rd, 0, 0, 32'h00C4_1235, 32'h0, 0, 32'h0, fill_word(32'h00C4_1235), 0);
    // inhibited enable, then the real miss
    add_row(op_rd, 0, 1, 32'h0003_0660, 32'h0, 0, 32'h0, 32'h0, 0);
    add_row(op_rd, 0, 0, 32'h0003_0660, 32'h0, 1, 32'h0003_0660, fill_word(32'h0003_0660), 0);
  endtask

  task automatic run_row(input int r);
    logic busy_seen;
    logic fault_seen;
    int   bus_base;
    int   act_base;
    while (cache_busy)
      next_cycle();
    bus_base = bus_cnt;
    act_base = act_cnt;
    cache_precycle_addr   = t_addr[r];
    cache_datao           = t_data[r];
    vmem_act              = t_vmem[r];
    cache_inhibit         = t_inh[r];
    cache_precycle_enable = (t_op[r] != op_tlb);
    cache_precycle_we     = (t_op[r] == op_wr);
    we_tlb                = (t_op[r] == op_tlb);
    next_cycle();                      // request taken, RAMs read
    cache_precycle_enable = 1'b0;
    cache_precycle_we     = 1'b0;
    we_tlb                = 1'b0;
    cache_inhibit         = 1'b0;
    next_cycle();                      // end of lookup
    busy_seen  = cache_busy;
    fault_seen = mmu_fault;
    while (cache_busy)
      next_cycle();
    check_value("mmu_fault", 32'(fault_seen), 32'(t_fault[r]));
    check_value("cache_busy", 32'(busy_seen), 32'(t_bus[r]));
    check_value("bus cycles", 32'(bus_cnt - bus_base), 32'(t_bus[r]));
    if (!t_bus[r])
      check_value("mem_do_act cycles", 32'(act_cnt - act_base), 32'd0);
    else
    begin
      check_value("mem_addr", bus_addr, t_bus_addr[r]);
      check_value("mem_we", 32'(bus_we), 32'(t_op[r] != op_rd));
      if (t_op[r] != op_rd)
        check_value("mem_dataintomem", bus_data, t_data[r]);
    end
    if (t_op[r] == op_rd && !t_inh[r] && !t_fault[r])
      check_value("cache_datai", cache_datai, t_rdata[r]);
    rows_done++;
  endtask

  task automatic print_summary();
    $display("summary: %0d rows, %0d checks, %0d errors", rows_done, chk_cnt,
             err_cnt + grant_err);
  endtask

  //--------------------------------------------------
  // main sequence
  //--------------------------------------------------
  initial
  begin
    RST = 1'b0;
    cache_precycle_addr = '0;
    cache_datao = '0;
    cache_precycle_we = 1'b0;
    cache_precycle_enable = 1'b0;
    cache_inhibit = 1'b0;
    vmem_act = 1'b0;
    we_tlb = 1'b0;
    load_table();
    repeat (5)
      next_cycle();
    RST = 1'b1;
    next_cycle();
    for (int r = 0; r < n_rows; r++)
      run_row(r);
    print_summary();
    if (err_cnt + grant_err == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  // run limit
  initial
  begin
    while (cycle_cnt < cycle_limit)
    begin
      @(posedge CPU_CLK);
      cycle_cnt++;
    end
    $display("timeout: no finish after %0d CPU_CLK cycles, row %0d", cycle_cnt, rows_done);
    print_summary();
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
//--------------------------------------------------
// tb_clock_gen
// free-running testbench clock, first rising edge
// at the phase offset
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int period_ns = 100,
  parameter int phase_ns  = 0
) (
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    #(phase_ns);                     // first rising edge
    forever
    begin
      clk = 1'b1;
      #(period_ns / 2);
      clk = 1'b0;
      #(period_ns - period_ns / 2);
    end
  end

endmodule

`default_nettype wire

// File: snowball_cache.sv
//--------------------------------------------------
// snowball_cache
// data cache and TLB for the CPU, bridging the CPU
// clock and the memory clock
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module snowball_cache (
  input  wire                          CPU_CLK,
  input  wire                          MCU_CLK,
  input  wire                          RST,
  input  wire [cache_pkg::addr_w-1:0]  cache_precycle_addr,
  input  wire [cache_pkg::data_w-1:0]  cache_datao,
  output wire [cache_pkg::data_w-1:0]  cache_datai,
  input  wire                          cache_precycle_we,
  input  wire                          cache_precycle_enable,
  input  wire                          cache_inhibit,
  input  wire                          vmem_act,
  input  wire                          we_tlb,
  output wire                          cache_busy,
  output wire                          mmu_fault,
  input  wire                          dma_mcu_access,
  output wire [cache_pkg::addr_w-1:0]  mem_addr,
  output wire [cache_pkg::data_w-1:0]  mem_dataintomem,
  output wire                          mem_we,
  output wire                          mem_do_act,
  input  wire                          mem_ack,
  input  wire [cache_pkg::data_w-1:0]  mem_datafrommem
);

  wire [cache_pkg::data_w-1:0]      cache_rdata;
  wire [cache_pkg::cache_tag_w-1:0] tag_rdata;
  wire [cache_pkg::page_w-1:0]      tlb_ptag;
  wire [cache_pkg::page_w-1:0]      tlb_vtag;
  wire                              ram_re;
  wire                              mem_start;
  wire                              mem_done;
  wire                              dat_we;
  wire [cache_pkg::ram_aw-1:0]      dat_waddr;
  wire [cache_pkg::data_w-1:0]      dat_wdata;
  wire [cache_pkg::cache_tag_w-1:0] tag_wdata;
  wire                              tlb_we;
  wire [cache_pkg::ram_aw-1:0]      tlb_waddr;
  wire [cache_pkg::page_w-1:0]      tlb_ptag_w;
  wire [cache_pkg::page_w-1:0]      tlb_vtag_w;

  xfer_if xfer ();

  cache_lookup u_lookup (
    .CPU_CLK, .RST, .cache_precycle_addr, .cache_datao, .cache_datai,
    .cache_precycle_we, .cache_precycle_enable, .cache_inhibit, .vmem_act,
    .we_tlb, .cache_busy, .mmu_fault, .cache_rdata, .tag_rdata, .tlb_ptag,
    .tlb_vtag, .ram_re, .mem_done, .xfer(xfer.cpu)
  );

  mem_sequencer u_seq (
    .MCU_CLK, .RST, .mem_start, .xfer(xfer.mem), .dma_mcu_access, .mem_ack,
    .mem_datafrommem, .mem_addr, .mem_dataintomem, .mem_we, .mem_do_act,
    .dat_we, .dat_waddr, .dat_wdata, .tag_wdata, .tlb_we, .tlb_waddr,
    .tlb_ptag_w, .tlb_vtag_w
  );

  //--------------------------------------------------
  // clock crossings
  //--------------------------------------------------
  event_sync u_req_sync (
    .clk(MCU_CLK), .RST, .toggle_in(xfer.req_toggle), .pulse(mem_start)
  );

  event_sync u_rsp_sync (
    .clk(CPU_CLK), .RST, .toggle_in(xfer.rsp_toggle), .pulse(mem_done)
  );

  //--------------------------------------------------
  // RAMs, read on CPU_CLK, written on MCU_CLK
  //--------------------------------------------------
  dual_clock_ram #(.width(cache_pkg::data_w)) u_cache_dat (
    .rclk(CPU_CLK), .re(ram_re),
    .raddr(cache_precycle_addr[cache_pkg::idx_hi:cache_pkg::idx_lo]),
    .rdata(cache_rdata), .wclk(MCU_CLK), .we(dat_we), .waddr(dat_waddr),
    .wdata(dat_wdata)
  );

  dual_clock_ram #(.width(cache_pkg::cache_tag_w)) u_cache_tag (
    .rclk(CPU_CLK), .re(ram_re),
    .raddr(cache_precycle_addr[cache_pkg::idx_hi:cache_pkg::idx_lo]),
    .rdata(tag_rdata), .wclk(MCU_CLK), .we(dat_we), .waddr(dat_waddr),
    .wdata(tag_wdata)
  );

  dual_clock_ram #(.width(cache_pkg::page_w)) u_tlb_ptag (
    .rclk(CPU_CLK), .re(ram_re),
    .raddr(cache_precycle_addr[cache_pkg::tlb_hi:cache_pkg::tlb_lo]),
    .rdata(tlb_ptag), .wclk(MCU_CLK), .we(tlb_we), .waddr(tlb_waddr),
    .wdata(tlb_ptag_w)
  );

  dual_clock_ram #(.width(cache_pkg::page_w)) u_tlb_vtag (
    .rclk(CPU_CLK), .re(ram_re),
    .raddr(cache_precycle_addr[cache_pkg::tlb_hi:cache_pkg::tlb_lo]),
    .rdata(tlb_vtag), .wclk(MCU_CLK), .we(tlb_we), .waddr(tlb_waddr),
    .wdata(tlb_vtag_w)
  );

endmodule

`default_nettype wire

// File: mem_sequencer.sv
//--------------------------------------------------
// mem_sequencer
// memory side: bus cycle, read fill of the word pair,
// cache and TLB RAM writes
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mem_sequencer (
  input  wire                               MCU_CLK,
  input  wire                               RST,
  input  wire                               mem_start,
  xfer_if.mem                               xfer,
  input  wire                               dma_mcu_access,
  input  wire                               mem_ack,
  input  wire [cache_pkg::data_w-1:0]       mem_datafrommem,
  output logic [cache_pkg::addr_w-1:0]      mem_addr,
  output logic [cache_pkg::data_w-1:0]      mem_dataintomem,
  output logic                              mem_we,
  output logic                              mem_do_act,
  output logic                              dat_we,
  output logic [cache_pkg::ram_aw-1:0]      dat_waddr,
  output logic [cache_pkg::data_w-1:0]      dat_wdata,
  output logic [cache_pkg::cache_tag_w-1:0] tag_wdata,
  output logic                              tlb_we,
  output logic [cache_pkg::ram_aw-1:0]      tlb_waddr,
  output logic [cache_pkg::page_w-1:0]      tlb_ptag_w,
  output logic [cache_pkg::page_w-1:0]      tlb_vtag_w
);

  logic                              op_we;
  logic                              op_tlb;
  logic                              op_wr;     // any bus write
  logic                              act_pre;   // strobe wanted
  logic                              do_act_q;
  logic                              ack_q;
  logic                              acked;     // registered ack seen
  logic                              cap_first;
  logic                              cap_second;
  logic [cache_pkg::cnt_w-1:0]       read_cnt;
  logic [cache_pkg::ram_aw-1:0]      line_idx;
  logic [cache_pkg::cache_tag_w-1:0] fill_tag_q;
  cache_pkg::tlb_entry_u             tlb_entry;

  assign op_wr      = op_we || op_tlb;
  assign acked      = do_act_q && ack_q;
  assign mem_do_act = act_pre && dma_mcu_access && !acked; // waits for the grant
  assign mem_we     = op_wr && mem_do_act;
  assign cap_first  = (read_cnt == cache_pkg::fill_first);
  assign cap_second = (read_cnt == cache_pkg::fill_second);

  //--------------------------------------------------
  // RAM write side
  //--------------------------------------------------
  assign tlb_entry.word = mem_dataintomem;
  assign dat_we     = (acked && op_we && !op_tlb) || cap_first || cap_second;
  assign dat_waddr  = line_idx;
  assign dat_wdata  = op_wr ? mem_dataintomem : mem_datafrommem;
  assign tag_wdata  = fill_tag_q;
  assign tlb_we     = acked && op_tlb;
  assign tlb_waddr  = mem_addr[cache_pkg::tlb_hi:cache_pkg::tlb_lo];
  assign tlb_ptag_w = tlb_entry.f.ptag;
  assign tlb_vtag_w = tlb_entry.f.vtag;

  always_ff @(posedge MCU_CLK)
  begin
    if (!RST)
    begin
      act_pre         <= 1'b0;
      do_act_q        <= 1'b0;
      ack_q           <= 1'b0;
      op_we           <= 1'b0;
      op_tlb          <= 1'b0;
      read_cnt        <= '0;
      xfer.rsp_toggle <= 1'b0;
    end
    else
    begin
      do_act_q <= mem_do_act;
      ack_q    <= mem_ack;
      if (mem_start)
      begin
        act_pre <= 1'b1;
        op_we   <= xfer.we;
        op_tlb  <= xfer.tlb_op;
      end
      else if (acked)
        act_pre <= 1'b0;
      // first word lands 2 cycles after the ack is registered
      if (mem_do_act && mem_ack && !op_wr)
        read_cnt <= cache_pkg::fill_start;
      else if (read_cnt != '0)
        read_cnt <= read_cnt + 1'b1; // wraps to idle after second word
      if ((acked && op_wr) || cap_first)
        xfer.rsp_toggle <= !xfer.rsp_toggle;
    end
  end

  always_ff @(posedge MCU_CLK)
  begin
    if (mem_start)
    begin
      mem_addr        <= xfer.phys_addr;
      mem_dataintomem <= xfer.wdata;
      fill_tag_q      <= xfer.fill_tag;
      line_idx        <= xfer.phys_addr[cache_pkg::idx_hi:cache_pkg::idx_lo];
    end
    else if (cap_first)
      line_idx <= {line_idx[cache_pkg::ram_aw-1:1], ~line_idx[0]}; // companion
    if (cap_first)
      xfer.fill_data <= mem_datafrommem;
  end

  // CPU side holds off until the previous cycle has fully finished
  a_no_overlap: assert property (@(posedge MCU_CLK) disable iff (!RST)
    mem_start |-> !act_pre && (read_cnt == '0));

endmodule

`default_nettype wire

// File: cache_lookup.sv
//--------------------------------------------------
// cache_lookup
// CPU side tag compare, translation and fault check,
// miss decision, busy and read data return
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cache_lookup (
  input  wire                               CPU_CLK,
  input  wire                               RST,
  input  wire [cache_pkg::addr_w-1:0]       cache_precycle_addr,
  input  wire [cache_pkg::data_w-1:0]       cache_datao,
  output logic [cache_pkg::data_w-1:0]      cache_datai,
  input  wire                               cache_precycle_we,
  input  wire                               cache_precycle_enable,
  input  wire                               cache_inhibit,
  input  wire                               vmem_act,
  input  wire                               we_tlb,
  output logic                              cache_busy,
  output logic                              mmu_fault,
  input  wire [cache_pkg::data_w-1:0]       cache_rdata,
  input  wire [cache_pkg::cache_tag_w-1:0]  tag_rdata,
  input  wire [cache_pkg::page_w-1:0]       tlb_ptag,
  input  wire [cache_pkg::page_w-1:0]       tlb_vtag,
  output logic                              ram_re,
  input  wire                               mem_done,
  xfer_if.cpu                               xfer
);

  logic                              cyc_vld;  // lookup cycle active
  logic                              cyc_tlb;
  logic                              cyc_we;
  logic                              cyc_vmem;
  logic [cache_pkg::addr_w-1:0]      cyc_addr;
  logic [cache_pkg::data_w-1:0]      cyc_wdata;
  logic                              pend_rd;  // read miss outstanding
  logic [cache_pkg::page_w-1:0]      vtag;
  logic [cache_pkg::page_w-1:0]      page_tag;
  logic [cache_pkg::cache_tag_w-1:0] req_tag;
  logic                              cache_work;
  logic                              accept;
  logic                              hit;
  logic                              fault;
  logic                              go_mem;

  assign cache_work = cache_precycle_enable && !cache_inhibit;
  // no new lookup on top of one that goes to memory
  assign accept     = (cache_work || we_tlb) && !cache_busy && !go_mem;
  assign ram_re     = cache_work && !cache_busy && !go_mem;

  //--------------------------------------------------
  // lookup cycle
  //--------------------------------------------------
  assign vtag     = cyc_addr[cache_pkg::vtag_hi:cache_pkg::vtag_lo];
  assign page_tag = (cyc_vmem && !cyc_tlb) ? tlb_ptag : vtag; // translated or flat
  assign req_tag  = {page_tag, cyc_addr[cache_pkg::tlb_hi:cache_pkg::tlb_lo]};
  assign hit      = (tag_rdata == req_tag);
  assign fault    = cyc_vld && cyc_vmem && !cyc_tlb && (tlb_vtag != vtag);
  assign go_mem   = cyc_vld && !fault && (cyc_tlb || cyc_we || !hit);

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      cyc_vld  <= 1'b0;
      cyc_tlb  <= 1'b0;
      cyc_we   <= 1'b0;
      cyc_vmem <= 1'b0;
    end
    else
    begin
      cyc_vld <= accept;
      if (accept)
      begin
        cyc_tlb  <= we_tlb;
        cyc_we   <= cache_precycle_we && !we_tlb;
        cyc_vmem <= vmem_act;
      end
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
    begin
      cyc_addr  <= cache_precycle_addr;
      cyc_wdata <= cache_datao;
    end
  end

  //--------------------------------------------------
  // request and busy
  //--------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      cache_busy      <= 1'b0;
      pend_rd         <= 1'b0;
      mmu_fault       <= 1'b0;
      xfer.req_toggle <= 1'b0;
    end
    else
    begin
      mmu_fault <= fault;
      if (go_mem)
      begin
        cache_busy      <= 1'b1;
        pend_rd         <= !(cyc_we || cyc_tlb);
        xfer.req_toggle <= !xfer.req_toggle;
      end
      else if (mem_done)
      begin
        cache_busy <= 1'b0;
        pend_rd    <= 1'b0;
      end
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (go_mem)
    begin
      xfer.phys_addr <= {page_tag, cyc_addr[cache_pkg::tlb_hi:cache_pkg::idx_lo]};
      xfer.wdata     <= cyc_wdata;
      xfer.we        <= cyc_we;
      xfer.tlb_op    <= cyc_tlb;
      xfer.fill_tag  <= req_tag;
    end
  end

  // hit data at end of lookup or fill word on response
  always_ff @(posedge CPU_CLK)
  begin
    if (cyc_vld && hit && !cyc_we && !cyc_tlb && !fault)
      cache_datai <= cache_rdata;
    else if (mem_done && pend_rd)
      cache_datai <= xfer.fill_data;
  end

  // responses only come back for an outstanding request
  a_busy_hold: assert property (@(posedge CPU_CLK) disable iff (!RST)
    mem_done |-> cache_busy);

  // a faulting lookup never reaches the memory domain
  a_fault_quiet: assert property (@(posedge CPU_CLK) disable iff (!RST)
    mmu_fault |-> $stable(xfer.req_toggle));

endmodule

`default_nettype wire

// File: dual_clock_ram.sv
//--------------------------------------------------
// dual_clock_ram
// simple dual-port block RAM, registered read on one
// clock and write on another
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dual_clock_ram #(
  parameter int width = 32
) (
  input  wire                          rclk,
  input  wire                          re,
  input  wire [cache_pkg::ram_aw-1:0]  raddr,
  output logic [width-1:0]             rdata,
  input  wire                          wclk,
  input  wire                          we,
  input  wire [cache_pkg::ram_aw-1:0]  waddr,
  input  wire [width-1:0]              wdata
);

  logic [width-1:0] mem [cache_pkg::ram_depth];

  always_ff @(posedge wclk)
  begin
    if (we)
      mem[waddr] <= wdata;
  end

  always_ff @(posedge rclk)
  begin
    if (re)
      rdata <= mem[raddr]; // holds last read otherwise
  end

endmodule

`default_nettype wire

// File: event_sync.sv
//--------------------------------------------------
// event_sync
// turns a toggle from another clock domain into a
// single-cycle pulse in the local domain
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module event_sync (
  input  wire clk,
  input  wire RST,
  input  wire toggle_in,
  output wire pulse
);

  logic [1:0] sync_q; // two-stage synchronizer
  logic       last_q;

  always_ff @(posedge clk)
  begin
    if (!RST)
    begin
      sync_q <= 2'b00;
      last_q <= 1'b0;
    end
    else
    begin
      sync_q <= {sync_q[0], toggle_in};
      last_q <= sync_q[1];
    end
  end

  assign pulse = sync_q[1] ^ last_q; // any edge of the toggle

endmodule

`default_nettype wire

// File: xfer_if.sv
//--------------------------------------------------
// xfer_if
// memory request handed from the CPU domain to the
// memory domain, with toggle events both ways
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface xfer_if;

  logic [cache_pkg::addr_w-1:0]      phys_addr;
  logic [cache_pkg::data_w-1:0]      wdata;
  logic                              we;
  logic                              tlb_op;
  logic [cache_pkg::cache_tag_w-1:0] fill_tag;   // tag written with the fill
  logic                              req_toggle; // flips once per request
  logic [cache_pkg::data_w-1:0]      fill_data;  // requested word, read miss
  logic                              rsp_toggle; // flips on ack or first fill word

  // fields stay put while a request is outstanding
  modport cpu (
    output phys_addr, wdata, we, tlb_op, fill_tag, req_toggle,
    input  fill_data, rsp_toggle
  );

  modport mem (
    input  phys_addr, wdata, we, tlb_op, fill_tag, req_toggle,
    output fill_data, rsp_toggle
  );

endinterface

`default_nettype wire

// File: cache_pkg.sv
//--------------------------------------------------
// cache_pkg
// widths, address fields, RAM sizes and read-fill
// timing shared by the cache and translation unit
//--------------------------------------------------
`default_nettype none

package cache_pkg;

  localparam int addr_w      = 32;
  localparam int data_w      = 32;

  //--------------------------------------------------
  // address fields
  //--------------------------------------------------
  localparam int idx_lo      = 0;  // cache line index
  localparam int idx_hi      = 7;
  localparam int tlb_lo      = 8;  // tlb index
  localparam int tlb_hi      = 15;
  localparam int vtag_lo     = 16; // page tag
  localparam int vtag_hi     = 31;
  localparam int page_w      = vtag_hi - vtag_lo + 1;
  localparam int cache_tag_w = 24; // page tag plus tlb index

  localparam int ram_depth   = 256;
  localparam int ram_aw      = $clog2(ram_depth);

  //--------------------------------------------------
  // read fill counter
  //--------------------------------------------------
  localparam int cnt_w = 3;
  localparam logic [cnt_w-1:0] fill_start  = 3'd4; // loaded on read ack
  localparam logic [cnt_w-1:0] fill_first  = 3'd6; // requested word
  localparam logic [cnt_w-1:0] fill_second = 3'd7; // companion word

  // tlb write word, physical tag in the upper half
  typedef struct packed {
    logic [page_w-1:0] ptag;
    logic [page_w-1:0] vtag;
  } tlb_fields_t;

  typedef union packed {
    logic [data_w-1:0] word;
    tlb_fields_t       f;
  } tlb_entry_u;

endpackage

`default_nettype wire
